/* Makefile */
# Verilator build and run of the datapath testbench

VERILATOR ?= verilator
TOP       ?= datapath_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+100
FAIL_MSG  ?= Something failed
PASS_MSG  ?= Everything OK

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard hw/*.svh)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	-$(BIN) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended early, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/datapath_properties.sv */
`timescale 1ns/1ns
`include "datapath_config.svh"

module datapath_properties (
	input logic                   clk,
	input logic                   rstN,
	input logic                   grb,
	input logic                   rOut,
	input logic                   baOut,
	input logic                   pcOut,
	input logic                   mdrOut,
	input logic                   zHiOut,
	input logic                   zLoOut,
	input logic                   inPortOut,
	input logic                   cOut,
	input logic [`DATA_WIDTH-1:0] irValue,
	input logic [`DATA_WIDTH-1:0] busValue,
	input logic [`DATA_WIDTH-1:0] pcValue,
	input logic [`DATA_WIDTH-1:0] outPort
);

	int assertFails = 0;
	datapath_pkg::instrT irWord;

	assign irWord = irValue;

	// Bus has one driver at most
	busOneSource: assert property (@(posedge clk) disable iff (!rstN)
		$onehot0({rOut, baOut, pcOut, mdrOut, zHiOut, zLoOut, inPortOut, cOut}))
		else begin
			assertFails++;
			$error("more than one bus source raised in the same step");
		end

	// R0 as a base address reads as zero
	baseZero: assert property (@(posedge clk) disable iff (!rstN)
		(baOut && grb && irWord.regForm.rb == '0) |-> busValue == '0)
		else begin
			assertFails++;
			$error("baOut of R0 put a nonzero value on the bus");
		end

	resetClean: assert property (@(posedge clk)
		$rose(rstN) |-> (pcValue == '0 && outPort == '0))
		else begin
			assertFails++;
			$error("PC or out port not zero after reset release");
		end

endmodule

bind datapath datapath_properties i_datapathProperties (
	.clk       (clk),
	.rstN      (rstN),
	.grb       (grb),
	.rOut      (rOut),
	.baOut     (baOut),
	.pcOut     (pcOut),
	.mdrOut    (mdrOut),
	.zHiOut    (zHiOut),
	.zLoOut    (zLoOut),
	.inPortOut (inPortOut),
	.cOut      (cOut),
	.irValue   (irValue),
	.busValue  (busValue),
	.pcValue   (pcValue),
	.outPort   (outPort)
);

/* dv/datapath_tb.sv */
`timescale 1ns/1ns
`include "datapath_config.svh"

module datapath_tb;

	localparam int W = `DATA_WIDTH;
	localparam int CLK_PERIOD = 20;
	localparam int RESET_CYCLES = 8;
	localparam int ALU_ROUNDS = 4;
	localparam int MUL_ROUNDS = 8;
	localparam int MEM_WORDS = 8;
	localparam int LOAD_STEPS = 18;
	// Steps of reset and of all six tests plus one idle step per test
	localparam int PLANNED_STEPS = RESET_CYCLES + 4 * 15 + 2 * 10 * ALU_ROUNDS
		+ 2 * MUL_ROUNDS + 5 * MEM_WORDS + 1 + 1 + 2 * LOAD_STEPS + 6;

	// Control pulse masks in the bit order of the ctrl assign below
	localparam logic [21:0] GRA       = 22'd1 << 0;
	localparam logic [21:0] GRB       = 22'd1 << 1;
	localparam logic [21:0] RIN       = 22'd1 << 3;
	localparam logic [21:0] ROUT      = 22'd1 << 4;
	localparam logic [21:0] BAOUT     = 22'd1 << 5;
	localparam logic [21:0] PCIN      = 22'd1 << 6;
	localparam logic [21:0] IRIN      = 22'd1 << 7;
	localparam logic [21:0] YIN       = 22'd1 << 8;
	localparam logic [21:0] ZIN       = 22'd1 << 9;
	localparam logic [21:0] MARIN     = 22'd1 << 10;
	localparam logic [21:0] MDRIN     = 22'd1 << 11;
	localparam logic [21:0] OUTPORTIN = 22'd1 << 12;
	localparam logic [21:0] PCOUT     = 22'd1 << 13;
	localparam logic [21:0] MDROUT    = 22'd1 << 14;
	localparam logic [21:0] ZLOOUT    = 22'd1 << 16;
	localparam logic [21:0] INPORTOUT = 22'd1 << 17;
	localparam logic [21:0] COUT      = 22'd1 << 18;
	localparam logic [21:0] MEMREAD   = 22'd1 << 19;
	localparam logic [21:0] RAMREAD   = 22'd1 << 20;
	localparam logic [21:0] RAMWRITE  = 22'd1 << 21;

	logic clk;
	logic rstN;
	logic gra, grb, grc, rIn, rOut, baOut;
	logic pcIn, irIn, yIn, zIn, marIn, mdrIn, outPortIn;
	logic pcOut, mdrOut, zHiOut, zLoOut, inPortOut, cOut;
	logic memRead, ramRead, ramWrite;
	datapath_pkg::aluOpT aluOp;
	logic [W-1:0] inPort;
	logic [W-1:0] busValue, pcValue, irValue, mdrValue, zLoValue, zHiValue, outPort;

	logic [21:0] ctrl;
	logic [W-1:0] lastBus;
	logic [W-1:0] a, b, got;
	logic [W-1:0] pcExp;
	logic [W-1:0] vals [`REG_COUNT];
	logic [W-1:0] memAddr [MEM_WORDS];
	logic [W-1:0] memData [MEM_WORDS];
	datapath_pkg::aluOpT op;
	datapath_pkg::aluOpT zOp;
	logic [2*W-1:0] expZ;
	event zReady;
	int passCount = 0;
	int failCount = 0;
	int failsAtStart = 0;
	int assertFails;

	assign {ramWrite, ramRead, memRead, cOut, inPortOut, zLoOut, zHiOut, mdrOut, pcOut,
		outPortIn, mdrIn, marIn, zIn, yIn, irIn, pcIn, baOut, rOut, rIn, grc, grb, gra} = ctrl;

	datapath i_datapath (.*);

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic logic [2*W-1:0] aluModel(input datapath_pkg::aluOpT fn,
			input logic [W-1:0] x, input logic [W-1:0] y);
		logic [W-1:0] w;
		logic [2*W-1:0] wideX;
		logic [2*W-1:0] wideY;
		wideX = {{W{x[W-1]}}, x};
		wideY = {{W{y[W-1]}}, y};
		case (fn)
			datapath_pkg::opAdd: w = x + y;
			datapath_pkg::opSub: w = x - y;
			datapath_pkg::opAnd: w = x & y;
			datapath_pkg::opOr: w = x | y;
			datapath_pkg::opShl: w = x << y[4:0];
			datapath_pkg::opShr: w = x >> y[4:0];
			datapath_pkg::opNeg: w = ~y + 1'b1;
			datapath_pkg::opNot: w = ~y;
			datapath_pkg::opIncPc: w = y + 1'b1;
			// Low 64 bits of the sign-extended product
			datapath_pkg::opMul: return wideX * wideY;
			default: w = y;
		endcase
		return {{W{w[W-1]}}, w};
	endfunction

	function automatic logic [W-1:0] raWord(input int idx);
		datapath_pkg::instrT w;
		w = '0;
		w.regForm.ra = datapath_pkg::regIdxT'(idx);
		return w;
	endfunction

	function automatic logic [W-1:0] ldWord(input int ra, input int rb, input int c);
		datapath_pkg::instrT w;
		w = '0;
		w.immForm.ra = datapath_pkg::regIdxT'(ra);
		w.immForm.rb = datapath_pkg::regIdxT'(rb);
		w.immForm.c = c[datapath_pkg::C_WIDTH-1:0];
		return w;
	endfunction

	task automatic flagMismatch(input string msg);
		$display("FAILED at %0t ns: %s", $time, msg);
		failCount++;
	endtask

	// Starts and ends on a falling edge
	task automatic step(input logic [21:0] pulses, input logic [W-1:0] data = '0,
			input datapath_pkg::aluOpT fn = datapath_pkg::opPassB);
		ctrl = pulses;
		inPort = data;
		aluOp = fn;
		#1;
		lastBus = busValue;
		@(posedge clk);
		@(negedge clk);
		ctrl = '0;
	endtask

	task automatic writeReg(input int idx, input logic [W-1:0] value);
		step(INPORTOUT | IRIN, raWord(idx));
		step(INPORTOUT | GRA | RIN, value);
	endtask

	task automatic readReg(input int idx, output logic [W-1:0] value);
		step(INPORTOUT | IRIN, raWord(idx));
		step(GRA | ROUT);
		value = lastBus;
	endtask

	task automatic storeWord(input logic [W-1:0] addr, input logic [W-1:0] data);
		step(INPORTOUT | MARIN, addr);
		step(INPORTOUT | MDRIN, data);
		step(RAMWRITE);
	endtask

	task automatic applyAlu(input datapath_pkg::aluOpT fn, input logic [W-1:0] x,
			input logic [W-1:0] y);
		step(INPORTOUT | YIN, x);
		step(INPORTOUT | ZIN, y, fn);
		zOp = fn;
		expZ = aluModel(fn, x, y);
		->zReady;
	endtask

	task automatic runLoad(input int ra, input int rb, input int c, input logic [W-1:0] base);
		logic [W-1:0] pcOld;
		logic [W-1:0] eff;
		logic [W-1:0] data;
		logic [W-1:0] value;
		// A zero rb ignores the R0 contents
		eff = (rb == 0) ? c : base + c;
		data = $urandom;
		writeReg(rb, base);
		pcOld = pcExp;
		storeWord(pcOld, ldWord(ra, rb, c));
		storeWord(eff, data);
		step(PCOUT | MARIN | ZIN, 0, datapath_pkg::opIncPc);
		step(ZLOOUT | PCIN | MEMREAD | RAMREAD | MDRIN);
		step(MDROUT | IRIN);
		step(GRB | BAOUT | YIN);
		step(COUT | ZIN, 0, datapath_pkg::opAdd);
		step(ZLOOUT | MARIN);
		step(MEMREAD | RAMREAD | MDRIN);
		step(MDROUT | GRA | RIN);
		readReg(ra, value);
		if (value !== data || pcValue !== pcOld + 1) begin
			flagMismatch($sformatf("ld R%0d got %h pc %h, expected %h pc %h",
				ra, value, pcValue, data, pcOld + 1));
		end else begin
			passCount++;
		end
		pcExp = pcOld + 1;
	endtask

	task automatic endTest(input string name);
		@(negedge clk);
		$display("Test %s done with %0d errors", name, failCount - failsAtStart);
		failsAtStart = failCount;
	endtask

	always @(zReady) begin
		if ({zHiValue, zLoValue} !== expZ) begin
			flagMismatch($sformatf("%s gave Z %h, expected %h", zOp.name(),
				{zHiValue, zLoValue}, expZ));
		end else begin
			passCount++;
		end
	end

	initial begin
		#(PLANNED_STEPS * CLK_PERIOD * 2);
		$display("Timeout: the tests did not finish within %0d ns",
			PLANNED_STEPS * CLK_PERIOD * 2);
		$display("Something failed");
		$finish;
	end

	initial begin
		void'($urandom(85));
		rstN = 1'b0;
		ctrl = '0;
		inPort = '0;
		aluOp = datapath_pkg::opAdd;
		pcExp = '0;
		repeat (RESET_CYCLES) @(negedge clk);
		rstN = 1'b1;
		if (pcValue !== '0 || irValue !== '0 || mdrValue !== '0 || zLoValue !== '0
			|| zHiValue !== '0 || outPort !== '0 || busValue !== '0) begin
			flagMismatch("registers or bus not zero after reset");
		end else begin
			passCount++;
		end
		endTest("reset");

		for (int r = 1; r < `REG_COUNT; r++) begin
			vals[r] = $urandom;
			writeReg(r, vals[r]);
		end
		for (int r = 1; r < `REG_COUNT; r++) begin
			readReg(r, got);
			if (got !== vals[r]) begin
				flagMismatch($sformatf("R%0d reads %h, wrote %h", r, got, vals[r]));
			end else begin
				passCount++;
			end
		end
		endTest("register");

		for (int k = 0; k <= 10; k++) begin
			op = datapath_pkg::aluOpT'(k);
			if (op != datapath_pkg::opMul) begin
				for (int n = 0; n < ALU_ROUNDS; n++) begin
					a = $urandom;
					b = $urandom;
					applyAlu(op, a, b);
				end
			end
		end
		endTest("alu");

		for (int k = 0; k < MUL_ROUNDS; k++) begin
			a = $urandom;
			b = $urandom;
			// All four sign combinations
			a[W-1] = k[0];
			b[W-1] = k[1];
			applyAlu(datapath_pkg::opMul, a, b);
		end
		endTest("multiply");

		for (int k = 0; k < MEM_WORDS; k++) begin
			// One address per slice of the RAM keeps them distinct
			memAddr[k] = k * (`MEM_DEPTH / MEM_WORDS)
				+ $urandom_range(`MEM_DEPTH / MEM_WORDS - 1);
			memData[k] = $urandom;
			storeWord(memAddr[k], memData[k]);
		end
		for (int k = 0; k < MEM_WORDS; k++) begin
			step(INPORTOUT | MARIN, memAddr[k]);
			step(MEMREAD | RAMREAD | MDRIN);
			if (mdrValue !== memData[k]) begin
				flagMismatch($sformatf("RAM[%0d] reads %h, stored %h", memAddr[k], mdrValue,
					memData[k]));
			end else begin
				passCount++;
			end
		end
		step(MDROUT | OUTPORTIN);
		if (outPort !== memData[MEM_WORDS-1]) begin
			flagMismatch($sformatf("out port %h, expected %h", outPort, memData[MEM_WORDS-1]));
		end else begin
			passCount++;
		end
		endTest("memory");

		pcExp = 32'h40;
		step(INPORTOUT | PCIN, pcExp);
		runLoad(5, 3, -32, 32'h120);
		runLoad(9, 0, 416, 32'h155);
		endTest("load");

		assertFails = i_datapath.i_datapathProperties.assertFails;
		$display("Checks passed %0d, failed %0d, assertion failures %0d",
			passCount, failCount, assertFails);
		if (failCount == 0 && assertFails == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

/* hw/alu.sv */
`timescale 1ns/1ns
`include "datapath_config.svh"

module alu (
	input  datapath_pkg::aluOpT      aluOp,
	input  logic [`DATA_WIDTH-1:0]   operandA,
	input  logic [`DATA_WIDTH-1:0]   operandB,
	output logic [2*`DATA_WIDTH-1:0] result
);

	localparam int SHIFT_BITS = $clog2(`DATA_WIDTH);

	logic [`DATA_WIDTH-1:0] word;
	logic signed [2*`DATA_WIDTH-1:0] product;
	logic [SHIFT_BITS-1:0] shiftAmt;

	// Both operands signed, so they widen by sign before the multiply
	assign product = $signed(operandA) * $signed(operandB);

	assign shiftAmt = operandB[SHIFT_BITS-1:0];

	always_comb begin
		case (aluOp)
			datapath_pkg::opAdd: begin
				word = operandA + operandB;
			end
			datapath_pkg::opSub: begin
				word = operandA - operandB;
			end
			datapath_pkg::opAnd: begin
				word = operandA & operandB;
			end
			datapath_pkg::opOr: begin
				word = operandA | operandB;
			end
			// Y is shifted, bus gives the count
			datapath_pkg::opShl: begin
				word = operandA << shiftAmt;
			end
			datapath_pkg::opShr: begin
				word = operandA >> shiftAmt;
			end
			datapath_pkg::opNeg: begin
				word = -operandB;
			end
			datapath_pkg::opNot: begin
				word = ~operandB;
			end
			datapath_pkg::opIncPc: begin
				word = operandB + 1'b1;
			end
			datapath_pkg::opPassB: begin
				word = operandB;
			end
			default: begin
				word = '0;
			end
		endcase
	end

	// Only the multiply fills Z high with real bits
	always_comb begin
		if (aluOp == datapath_pkg::opMul) begin
			result = product;
		end else begin
			result = {{`DATA_WIDTH{word[`DATA_WIDTH-1]}}, word};
		end
	end

endmodule

/* hw/datapath.sv */
`timescale 1ns/1ns
`include "datapath_config.svh"

module datapath (
	input  logic                   clk,
	input  logic                   rstN,
	input  logic                   gra,
	input  logic                   grb,
	input  logic                   grc,
	input  logic                   rIn,
	input  logic                   rOut,
	input  logic                   baOut,
	input  logic                   pcIn,
	input  logic                   irIn,
	input  logic                   yIn,
	input  logic                   zIn,
	input  logic                   marIn,
	input  logic                   mdrIn,
	input  logic                   outPortIn,
	input  logic                   pcOut,
	input  logic                   mdrOut,
	input  logic                   zHiOut,
	input  logic                   zLoOut,
	input  logic                   inPortOut,
	input  logic                   cOut,
	input  logic                   memRead,
	input  logic                   ramRead,
	input  logic                   ramWrite,
	input  datapath_pkg::aluOpT    aluOp,
	input  logic [`DATA_WIDTH-1:0] inPort,
	output logic [`DATA_WIDTH-1:0] busValue,
	output logic [`DATA_WIDTH-1:0] pcValue,
	output logic [`DATA_WIDTH-1:0] irValue,
	output logic [`DATA_WIDTH-1:0] mdrValue,
	output logic [`DATA_WIDTH-1:0] zLoValue,
	output logic [`DATA_WIDTH-1:0] zHiValue,
	output logic [`DATA_WIDTH-1:0] outPort
);

	localparam int W = `DATA_WIDTH;
	localparam int CW = datapath_pkg::C_WIDTH;

	logic [W-1:0] pc;
	datapath_pkg::instrT ir;
	logic [W-1:0] y;
	logic [W-1:0] zHi;
	logic [W-1:0] zLo;
	logic [W-1:0] outReg;
	logic [W-1:0] regValue;
	logic [W-1:0] cValue;
	logic [2*W-1:0] aluResult;

	regFile i_regFile (
		.clk       (clk),
		.rstN      (rstN),
		.instrWord (ir),
		.gra       (gra),
		.grb       (grb),
		.grc       (grc),
		.rIn       (rIn),
		.rOut      (rOut),
		.baOut     (baOut),
		.busIn     (busValue),
		.regValue  (regValue)
	);

	alu i_alu (
		.aluOp    (aluOp),
		.operandA (y),
		.operandB (busValue),
		.result   (aluResult)
	);

	memUnit i_memUnit (
		.clk      (clk),
		.rstN     (rstN),
		.marIn    (marIn),
		.mdrIn    (mdrIn),
		.memRead  (memRead),
		.ramRead  (ramRead),
		.ramWrite (ramWrite),
		.busIn    (busValue),
		.mdrValue (mdrValue)
	);

	// Sign-extended constant from the immediate view of IR
	assign cValue = {{(W - CW){ir.immForm.c[CW-1]}}, ir.immForm.c};

	// AND-OR bus mux, regValue is already zero unless rOut or baOut
	assign busValue = regValue
		| ({W{pcOut}} & pc)
		| ({W{mdrOut}} & mdrValue)
		| ({W{zHiOut}} & zHi)
		| ({W{zLoOut}} & zLo)
		| ({W{inPortOut}} & inPort)
		| ({W{cOut}} & cValue);

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pc <= '0;
			ir <= '0;
			y <= '0;
			zHi <= '0;
			zLo <= '0;
			outReg <= '0;
		end else begin
			if (pcIn) begin
				pc <= busValue;
			end
			if (irIn) begin
				ir <= busValue;
			end
			if (yIn) begin
				y <= busValue;
			end
			// Z captures the full 64-bit ALU result
			if (zIn) begin
				{zHi, zLo} <= aluResult;
			end
			if (outPortIn) begin
				outReg <= busValue;
			end
		end
	end

	assign pcValue = pc;
	assign irValue = ir;
	assign zLoValue = zLo;
	assign zHiValue = zHi;
	assign outPort = outReg;

endmodule

/* hw/datapath_config.svh */
`ifndef DATAPATH_CONFIG_SVH
`define DATAPATH_CONFIG_SVH

// Width of the bus and of every datapath register
`define DATA_WIDTH 32

// General purpose registers R0 to R15
`define REG_COUNT 16

// Word-addressed RAM, only the low MAR bits reach it
`define MEM_DEPTH 512
`define ADDR_WIDTH 9

`endif

/* hw/datapath_pkg.sv */
`include "datapath_config.svh"

package datapath_pkg;

	localparam int OPCODE_WIDTH = 5;
	localparam int IDX_WIDTH = $clog2(`REG_COUNT);
	// Constant field fills what is left after opcode, ra and rb
	localparam int C_WIDTH = `DATA_WIDTH - OPCODE_WIDTH - 2 * IDX_WIDTH;

	typedef enum logic [3:0] {
		opAdd   = 4'd0,
		opSub   = 4'd1,
		opAnd   = 4'd2,
		opOr    = 4'd3,
		opShl   = 4'd4,
		opShr   = 4'd5,
		opNeg   = 4'd6,
		opNot   = 4'd7,
		// Bus operand plus one, used for the PC
		opIncPc = 4'd8,
		opMul   = 4'd9,
		opPassB = 4'd10
	} aluOpT;

	typedef logic [IDX_WIDTH-1:0] regIdxT;

	// Three-register format
	typedef struct packed {
		logic [OPCODE_WIDTH-1:0] opcode;
		regIdxT ra;
		regIdxT rb;
		regIdxT rc;
		logic [C_WIDTH-IDX_WIDTH-1:0] unused;
	} instrRegT;

	// Register plus signed constant format, as used by ld
	typedef struct packed {
		logic [OPCODE_WIDTH-1:0] opcode;
		regIdxT ra;
		regIdxT rb;
		logic signed [C_WIDTH-1:0] c;
	} instrImmT;

	typedef union packed {
		instrRegT regForm;
		instrImmT immForm;
	} instrT;

endpackage

/* hw/memUnit.sv */
`timescale 1ns/1ns
`include "datapath_config.svh"

module memUnit (
	input  logic                   clk,
	input  logic                   rstN,
	input  logic                   marIn,
	input  logic                   mdrIn,
	input  logic                   memRead,
	input  logic                   ramRead,
	input  logic                   ramWrite,
	input  logic [`DATA_WIDTH-1:0] busIn,
	output logic [`DATA_WIDTH-1:0] mdrValue
);

	// MAR keeps only the bits that reach the RAM
	logic [`ADDR_WIDTH-1:0] mar;
	logic [`DATA_WIDTH-1:0] mdr;
	logic [`DATA_WIDTH-1:0] mdrNext;
	logic [`DATA_WIDTH-1:0] ramWord;
	logic [`DATA_WIDTH-1:0] ram [`MEM_DEPTH];

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			mar <= '0;
		end else if (marIn) begin
			mar <= busIn[`ADDR_WIDTH-1:0];
		end
	end

	// Asynchronous read, data is there in the same step
	assign ramWord = ram[mar];

	// MDR input mux, RAM word only when both read strobes are up
	always_comb begin
		if (memRead && ramRead) begin
			mdrNext = ramWord;
		end else begin
			mdrNext = busIn;
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			mdr <= '0;
		end else if (mdrIn) begin
			mdr <= mdrNext;
		end
	end

	// Store takes the MDR value held during the step
	always_ff @(posedge clk) begin
		if (ramWrite) begin
			ram[mar] <= mdr;
		end
	end

	assign mdrValue = mdr;

endmodule

/* hw/regFile.sv */
`timescale 1ns/1ns
`include "datapath_config.svh"

module regFile (
	input  logic                   clk,
	input  logic                   rstN,
	input  datapath_pkg::instrT    instrWord,
	input  logic                   gra,
	input  logic                   grb,
	input  logic                   grc,
	input  logic                   rIn,
	input  logic                   rOut,
	input  logic                   baOut,
	input  logic [`DATA_WIDTH-1:0] busIn,
	output logic [`DATA_WIDTH-1:0] regValue
);

	logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];
	datapath_pkg::regIdxT regIdx;
	logic baseZero;

	// Field select from the IR, only one of gra, grb, grc is raised per step
	always_comb begin
		if (gra) begin
			regIdx = instrWord.regForm.ra;
		end else if (grb) begin
			regIdx = instrWord.regForm.rb;
		end else if (grc) begin
			regIdx = instrWord.regForm.rc;
		end else begin
			regIdx = '0;
		end
	end

	// Base address read of R0 gives zero for register-indirect addressing
	assign baseZero = baOut && (regIdx == '0);

	always_comb begin
		if ((rOut || baOut) && !baseZero) begin
			regValue = regs[regIdx];
		end else begin
			regValue = '0;
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (rIn) begin
			regs[regIdx] <= busIn;
		end
	end

endmodule

/* tb.f */
+incdir+hw
hw/datapath_pkg.sv
hw/regFile.sv
hw/alu.sv
hw/memUnit.sv
hw/datapath.sv
dv/datapath_properties.sv
dv/datapath_tb.sv
